//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_bypass_core
FILELIST   ?= compile.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing
PASS_TEXT  ?= TESTBENCH PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- compile.f
hdl/rv_bypass_pkg.sv
hdl/issue_decode.sv
hdl/reg_file.sv
hdl/operand_bypass.sv
hdl/alu_stage.sv
hdl/writeback_stage.sv
hdl/bypass_core_top.sv
test/retire_checker.sv
test/tb_bypass_core.sv

//--- hdl/alu_stage.sv
`timescale 1ns/10ps
`default_nettype none

module alu_stage (
    input  wire logic                                     clk,
    input  wire logic                                     rst_n,
    input  wire logic                                     id_valid,
    input  wire logic [rv_bypass_pkg::reg_addr_width-1:0] id_rd,
    input  wire logic [rv_bypass_pkg::alu_op_width-1:0]   id_alu_op,
    input  wire logic [rv_bypass_pkg::xlen-1:0]           op_a,
    input  wire logic [rv_bypass_pkg::xlen-1:0]           op_b,
    output logic                                          ex_valid,
    output logic [rv_bypass_pkg::reg_addr_width-1:0]      ex_rd,
    output logic [rv_bypass_pkg::xlen-1:0]                ex_result,
    output logic                                          mem_valid,
    output logic [rv_bypass_pkg::reg_addr_width-1:0]      mem_rd,
    output logic [rv_bypass_pkg::xlen-1:0]                mem_result
);
    import rv_bypass_pkg::*;

    logic [alu_op_width-1:0] ex_op;
    logic [xlen-1:0]         ex_a;
    logic [xlen-1:0]         ex_b;
    logic                    ex_lt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
            ex_rd    <= '0;
            ex_op    <= alu_add;
            ex_a     <= '0;
            ex_b     <= '0;
        end else begin
            ex_valid <= id_valid;
            ex_rd    <= id_rd;
            ex_op    <= id_alu_op;
            ex_a     <= op_a;
            ex_b     <= op_b;
        end
    end

    assign ex_lt = $signed(ex_a) < $signed(ex_b);

    always_comb begin
        case (ex_op)
            alu_add: ex_result = ex_a + ex_b;
            alu_sub: ex_result = ex_a - ex_b;
            alu_and: ex_result = ex_a & ex_b;
            alu_or:  ex_result = ex_a | ex_b;
            alu_xor: ex_result = ex_a ^ ex_b;
            alu_sll: ex_result = ex_a << ex_b[5:0];
            alu_srl: ex_result = ex_a >> ex_b[5:0];
            alu_slt: ex_result = {{(xlen-1){1'b0}}, ex_lt};
            default: ex_result = '0;
        endcase
    end

    // mem stage only carries the result on
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_valid  <= 1'b0;
            mem_rd     <= '0;
            mem_result <= '0;
        end else begin
            mem_valid  <= ex_valid;
            mem_rd     <= ex_rd;
            mem_result <= ex_result;
        end
    end

endmodule

`default_nettype wire

//--- hdl/bypass_core_top.sv
`timescale 1ns/10ps
`default_nettype none

module bypass_core_top (
    input  wire logic                                     clk,
    input  wire logic                                     rst_n,
    input  wire logic                                     instr_valid,
    input  wire logic [31:0]                              instr,
    output logic                                          retire_valid,
    output logic [rv_bypass_pkg::reg_addr_width-1:0]      retire_rd,
    output logic [rv_bypass_pkg::xlen-1:0]                retire_data
);
    import rv_bypass_pkg::*;

    logic                      id_valid;
    logic [reg_addr_width-1:0] id_rs1;
    logic [reg_addr_width-1:0] id_rs2;
    logic [reg_addr_width-1:0] id_rd;
    logic [alu_op_width-1:0]   id_alu_op;
    logic                      id_use_imm;
    logic [xlen-1:0]           id_imm;
    logic [xlen-1:0]           rf_rdata1;
    logic [xlen-1:0]           rf_rdata2;
    logic [xlen-1:0]           op_a;
    logic [xlen-1:0]           op_b;
    logic                      ex_valid;
    logic [reg_addr_width-1:0] ex_rd;
    logic [xlen-1:0]           ex_result;
    logic                      mem_valid;
    logic [reg_addr_width-1:0] mem_rd;
    logic [xlen-1:0]           mem_result;
    logic                      wb_valid;
    logic [reg_addr_width-1:0] wb_rd;
    logic [xlen-1:0]           wb_result;

    issue_decode u_issue_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .id_valid    (id_valid),
        .id_rs1      (id_rs1),
        .id_rs2      (id_rs2),
        .id_rd       (id_rd),
        .id_alu_op   (id_alu_op),
        .id_use_imm  (id_use_imm),
        .id_imm      (id_imm)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr1 (id_rs1),
        .raddr2 (id_rs2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (wb_valid),
        .waddr  (wb_rd),
        .wdata  (wb_result)
    );

    operand_bypass u_operand_bypass (
        .id_rs1     (id_rs1),
        .id_rs2     (id_rs2),
        .id_use_imm (id_use_imm),
        .id_imm     (id_imm),
        .rf_rdata1  (rf_rdata1),
        .rf_rdata2  (rf_rdata2),
        .ex_valid   (ex_valid),
        .ex_rd      (ex_rd),
        .ex_result  (ex_result),
        .mem_valid  (mem_valid),
        .mem_rd     (mem_rd),
        .mem_result (mem_result),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_result  (wb_result),
        .op_a       (op_a),
        .op_b       (op_b)
    );

    alu_stage u_alu_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .id_valid   (id_valid),
        .id_rd      (id_rd),
        .id_alu_op  (id_alu_op),
        .op_a       (op_a),
        .op_b       (op_b),
        .ex_valid   (ex_valid),
        .ex_rd      (ex_rd),
        .ex_result  (ex_result),
        .mem_valid  (mem_valid),
        .mem_rd     (mem_rd),
        .mem_result (mem_result)
    );

    writeback_stage u_writeback_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .mem_valid  (mem_valid),
        .mem_rd     (mem_rd),
        .mem_result (mem_result),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_result  (wb_result)
    );

    assign retire_valid = wb_valid;
    assign retire_rd    = wb_rd;
    assign retire_data  = wb_result;

endmodule

`default_nettype wire

//--- hdl/issue_decode.sv
`timescale 1ns/10ps
`default_nettype none

module issue_decode (
    input  wire logic                                     clk,
    input  wire logic                                     rst_n,
    input  wire logic                                     instr_valid,
    input  wire logic [31:0]                              instr,
    output logic                                          id_valid,
    output logic [rv_bypass_pkg::reg_addr_width-1:0]      id_rs1,
    output logic [rv_bypass_pkg::reg_addr_width-1:0]      id_rs2,
    output logic [rv_bypass_pkg::reg_addr_width-1:0]      id_rd,
    output logic [rv_bypass_pkg::alu_op_width-1:0]        id_alu_op,
    output logic                                          id_use_imm,
    output logic [rv_bypass_pkg::xlen-1:0]                id_imm
);
    import rv_bypass_pkg::*;

    logic      word_valid;
    rv_instr_u word;
    logic      supported;
    logic      f7_zero;
    logic      f7_alt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_valid <= 1'b0;
            word       <= '0;
        end else begin
            word_valid <= instr_valid;
            word       <= instr;
        end
    end

    assign f7_zero = (word.r.funct7 == 7'b0000000);
    assign f7_alt  = (word.r.funct7 == 7'b0100000); // sub encoding

    always_comb begin
        supported  = 1'b0;
        id_alu_op  = alu_add;
        id_use_imm = 1'b0;
        id_imm     = '0;
        id_rs1     = word.r.rs1; // same bits in the i view
        id_rs2     = word.r.rs2;
        id_rd      = word.r.rd;
        case (word.r.opcode)
            opcode_op: begin
                supported = f7_zero;
                case (word.r.funct3)
                    3'b000: begin
                        supported = f7_zero || f7_alt;
                        id_alu_op = f7_alt ? alu_sub : alu_add;
                    end
                    3'b001:  id_alu_op = alu_sll;
                    3'b010:  id_alu_op = alu_slt;
                    3'b100:  id_alu_op = alu_xor;
                    3'b101:  id_alu_op = alu_srl;
                    3'b110:  id_alu_op = alu_or;
                    3'b111:  id_alu_op = alu_and;
                    default: supported = 1'b0; // sltu not handled
                endcase
            end
            opcode_op_imm: begin
                id_use_imm = 1'b1;
                id_rs2     = '0; // unused read port sits on x0
                id_imm     = {{(xlen-12){word.i.imm[11]}}, word.i.imm};
                supported  = 1'b1;
                case (word.i.funct3)
                    3'b000:  id_alu_op = alu_add;
                    3'b010:  id_alu_op = alu_slt;
                    3'b100:  id_alu_op = alu_xor;
                    3'b110:  id_alu_op = alu_or;
                    3'b111:  id_alu_op = alu_and;
                    default: supported = 1'b0; // immediate shifts left out
                endcase
            end
            default: supported = 1'b0;
        endcase
    end

    assign id_valid = word_valid && supported && (id_rd != '0);

endmodule

`default_nettype wire

//--- hdl/operand_bypass.sv
`timescale 1ns/10ps
`default_nettype none

module operand_bypass (
    input  wire logic [rv_bypass_pkg::reg_addr_width-1:0] id_rs1,
    input  wire logic [rv_bypass_pkg::reg_addr_width-1:0] id_rs2,
    input  wire logic                                     id_use_imm,
    input  wire logic [rv_bypass_pkg::xlen-1:0]           id_imm,
    input  wire logic [rv_bypass_pkg::xlen-1:0]           rf_rdata1,
    input  wire logic [rv_bypass_pkg::xlen-1:0]           rf_rdata2,
    input  wire logic                                     ex_valid,
    input  wire logic [rv_bypass_pkg::reg_addr_width-1:0] ex_rd,
    input  wire logic [rv_bypass_pkg::xlen-1:0]           ex_result,
    input  wire logic                                     mem_valid,
    input  wire logic [rv_bypass_pkg::reg_addr_width-1:0] mem_rd,
    input  wire logic [rv_bypass_pkg::xlen-1:0]           mem_result,
    input  wire logic                                     wb_valid,
    input  wire logic [rv_bypass_pkg::reg_addr_width-1:0] wb_rd,
    input  wire logic [rv_bypass_pkg::xlen-1:0]           wb_result,
    output logic [rv_bypass_pkg::xlen-1:0]                op_a,
    output logic [rv_bypass_pkg::xlen-1:0]                op_b
);
    import rv_bypass_pkg::*;

    // youngest matching producer wins
    function automatic logic [xlen-1:0] pick_operand(
        input logic [reg_addr_width-1:0] addr,
        input logic [xlen-1:0]           rf_data
    );
        logic            hit_ex;
        logic            hit_mem;
        logic            hit_wb;
        logic [xlen-1:0] value;
        hit_ex  = ex_valid  && (ex_rd  != '0) && (ex_rd  == addr);
        hit_mem = mem_valid && (mem_rd != '0) && (mem_rd == addr);
        hit_wb  = wb_valid  && (wb_rd  != '0) && (wb_rd  == addr);
        if (hit_ex) begin
            value = ex_result;
        end else if (hit_mem) begin
            value = mem_result;
        end else if (hit_wb) begin
            value = wb_result; // not yet in the register file
        end else begin
            value = rf_data;
        end
        return value;
    endfunction

    always_comb begin
        op_a = pick_operand(id_rs1, rf_rdata1);
        if (id_use_imm) begin
            op_b = id_imm;
        end else begin
            op_b = pick_operand(id_rs2, rf_rdata2);
        end
    end

endmodule

`default_nettype wire

//--- hdl/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file (
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    input  wire logic [rv_bypass_pkg::reg_addr_width-1:0] raddr1,
    input  wire logic [rv_bypass_pkg::reg_addr_width-1:0] raddr2,
    output logic [rv_bypass_pkg::xlen-1:0]           rdata1,
    output logic [rv_bypass_pkg::xlen-1:0]           rdata2,
    input  wire logic                                we,
    input  wire logic [rv_bypass_pkg::reg_addr_width-1:0] waddr,
    input  wire logic [rv_bypass_pkg::xlen-1:0]      wdata
);
    import rv_bypass_pkg::*;

    logic [xlen-1:0] regs [reg_depth];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int n = 0; n < reg_depth; n++) begin
                regs[n] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 is hardwired
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

//--- hdl/rv_bypass_pkg.sv
`default_nettype none

package rv_bypass_pkg;

    localparam int xlen           = 64;
    localparam int reg_addr_width = 5;
    localparam int reg_depth      = 32;
    localparam int alu_op_width   = 4;

    // internal alu op codes
    localparam logic [alu_op_width-1:0] alu_add = 4'd0;
    localparam logic [alu_op_width-1:0] alu_sub = 4'd1;
    localparam logic [alu_op_width-1:0] alu_and = 4'd2;
    localparam logic [alu_op_width-1:0] alu_or  = 4'd3;
    localparam logic [alu_op_width-1:0] alu_xor = 4'd4;
    localparam logic [alu_op_width-1:0] alu_sll = 4'd5;
    localparam logic [alu_op_width-1:0] alu_srl = 4'd6;
    localparam logic [alu_op_width-1:0] alu_slt = 4'd7;

    localparam logic [6:0] opcode_op     = 7'b0110011;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;

    typedef struct packed {
        logic [6:0]                funct7;
        logic [reg_addr_width-1:0] rs2;
        logic [reg_addr_width-1:0] rs1;
        logic [2:0]                funct3;
        logic [reg_addr_width-1:0] rd;
        logic [6:0]                opcode;
    } rv_r_t;

    typedef struct packed {
        logic [11:0]               imm;
        logic [reg_addr_width-1:0] rs1;
        logic [2:0]                funct3;
        logic [reg_addr_width-1:0] rd;
        logic [6:0]                opcode;
    } rv_i_t;

    // one instruction word, two views
    typedef union packed {
        rv_r_t r;
        rv_i_t i;
    } rv_instr_u;

endpackage

`default_nettype wire

//--- hdl/writeback_stage.sv
`timescale 1ns/10ps
`default_nettype none

module writeback_stage (
    input  wire logic                                     clk,
    input  wire logic                                     rst_n,
    input  wire logic                                     mem_valid,
    input  wire logic [rv_bypass_pkg::reg_addr_width-1:0] mem_rd,
    input  wire logic [rv_bypass_pkg::xlen-1:0]           mem_result,
    output logic                                          wb_valid,
    output logic [rv_bypass_pkg::reg_addr_width-1:0]      wb_rd,
    output logic [rv_bypass_pkg::xlen-1:0]                wb_result
);

    // feeds retire, rf write and the oldest forward path
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid  <= 1'b0;
            wb_rd     <= '0;
            wb_result <= '0;
        end else begin
            wb_valid  <= mem_valid;
            wb_rd     <= mem_rd;
            wb_result <= mem_result;
        end
    end

endmodule

`default_nettype wire

//--- test/retire_checker.sv
`timescale 1ns/10ps
`default_nettype none

module retire_checker (
    input  wire logic                                     clk,
    input  wire logic                                     rst_n,
    input  wire logic [1:0]                               phase,
    input  wire logic                                     instr_valid,
    input  wire logic [31:0]                              instr,
    input  wire logic                                     retire_valid,
    input  wire logic [rv_bypass_pkg::reg_addr_width-1:0] retire_rd,
    input  wire logic [rv_bypass_pkg::xlen-1:0]           retire_data,
    output int                                            mismatch_count,
    output int                                            missing_count,
    output int                                            unexpected_count,
    output int                                            pending
);
    import rv_bypass_pkg::*;

    localparam int latency = 4; // edges from sampling to retire

    logic [xlen-1:0]           model_regs [reg_depth];
    int                        cyc;
    int                        seq;
    int                        mismatches = 0;
    int                        missing    = 0;
    int                        unexpected = 0;
    int                        due_q   [$];
    int                        seq_q   [$];
    logic [1:0]                phase_q [$];
    logic [reg_addr_width-1:0] rd_q    [$];
    logic [xlen-1:0]           data_q  [$];

    function automatic string phase_name(input logic [1:0] p);
        case (p)
            2'd0:    return "reset";
            2'd1:    return "directed";
            default: return "random_stream";
        endcase
    endfunction

    // architectural result; ok low for words outside the subset
    task automatic execute(input logic [31:0] word, output logic ok,
                           output logic [reg_addr_width-1:0] rd, output logic [xlen-1:0] res);
        rv_instr_u       w;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic            lt;
        w   = word;
        a   = model_regs[w.r.rs1];
        b   = '0;
        ok  = 1'b1;
        rd  = w.r.rd;
        res = '0;
        if (w.r.opcode == opcode_op) begin
            b  = model_regs[w.r.rs2];
            lt = $signed(a) < $signed(b);
            case ({w.r.funct7, w.r.funct3})
                10'b0000000_000: res = a + b;
                10'b0100000_000: res = a - b;
                10'b0000000_001: res = a << b[5:0];
                10'b0000000_010: res = {{(xlen-1){1'b0}}, lt};
                10'b0000000_100: res = a ^ b;
                10'b0000000_101: res = a >> b[5:0];
                10'b0000000_110: res = a | b;
                10'b0000000_111: res = a & b;
                default:         ok = 1'b0;
            endcase
        end else if (w.i.opcode == opcode_op_imm) begin
            b  = {{(xlen-12){w.i.imm[11]}}, w.i.imm};
            lt = $signed(a) < $signed(b);
            case (w.i.funct3)
                3'b000:  res = a + b;
                3'b010:  res = {{(xlen-1){1'b0}}, lt};
                3'b100:  res = a ^ b;
                3'b110:  res = a | b;
                3'b111:  res = a & b;
                default: ok = 1'b0;
            endcase
        end else begin
            ok = 1'b0;
        end
    endtask

    always @(posedge clk or negedge rst_n) begin
        logic                      ok;
        logic [reg_addr_width-1:0] rd;
        logic [xlen-1:0]           res;
        if (!rst_n) begin
            if (retire_valid === 1'b1) begin
                $display("error: retire_valid high during reset");
                unexpected++;
            end
            for (int n = 0; n < reg_depth; n++) begin
                model_regs[n] = '0;
            end
            due_q.delete();
            seq_q.delete();
            phase_q.delete();
            rd_q.delete();
            data_q.delete();
            cyc = 0;
            seq = 0;
        end else begin
            while (due_q.size() > 0 && due_q[0] < cyc) begin
                $display("error: %s instruction %0d to x%0d never retired",
                         phase_name(phase_q[0]), seq_q[0], rd_q[0]);
                missing++;
                void'(due_q.pop_front());
                void'(seq_q.pop_front());
                void'(phase_q.pop_front());
                void'(rd_q.pop_front());
                void'(data_q.pop_front());
            end
            if (retire_valid) begin
                if (due_q.size() == 0 || due_q[0] != cyc) begin
                    $display("error: unexpected retire to x%0d at cycle %0d", retire_rd, cyc);
                    unexpected++;
                end else begin
                    if (retire_rd !== rd_q[0] || retire_data !== data_q[0]) begin
                        $display("mismatch %s instr %0d: expected x%0d=%h actual x%0d=%h",
                                 phase_name(phase_q[0]), seq_q[0], rd_q[0], data_q[0],
                                 retire_rd, retire_data);
                        mismatches++;
                    end
                    void'(due_q.pop_front());
                    void'(seq_q.pop_front());
                    void'(phase_q.pop_front());
                    void'(rd_q.pop_front());
                    void'(data_q.pop_front());
                end
            end
            if (instr_valid) begin
                execute(instr, ok, rd, res);
                if (ok && rd != '0) begin // x0 writes never retire
                    model_regs[rd] = res;
                    due_q.push_back(cyc + latency);
                    seq_q.push_back(seq);
                    phase_q.push_back(phase);
                    rd_q.push_back(rd);
                    data_q.push_back(res);
                end
                seq++;
            end
            cyc++;
        end
        mismatch_count   <= mismatches;
        missing_count    <= missing;
        unexpected_count <= unexpected;
        pending          <= due_q.size();
    end

endmodule

`default_nettype wire

//--- test/tb_bypass_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_bypass_core;
    import rv_bypass_pkg::*;

    localparam int seed_value   = 85296;
    localparam int random_count = 300;
    localparam int drain_limit  = 50;

    logic                      clk;
    logic                      rst_n;
    logic                      instr_valid;
    logic [31:0]               instr;
    logic [1:0]                phase;
    logic                      retire_valid;
    logic [reg_addr_width-1:0] retire_rd;
    logic [xlen-1:0]           retire_data;
    int                        mismatch_count;
    int                        missing_count;
    int                        unexpected_count;
    int                        pending;

    bypass_core_top dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    retire_checker retire_check_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .phase            (phase),
        .instr_valid      (instr_valid),
        .instr            (instr),
        .retire_valid     (retire_valid),
        .retire_rd        (retire_rd),
        .retire_data      (retire_data),
        .mismatch_count   (mismatch_count),
        .missing_count    (missing_count),
        .unexpected_count (unexpected_count),
        .pending          (pending)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] enc_r(input logic [6:0] funct7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] funct3,
                                          input logic [4:0] rd);
        return {funct7, rs2, rs1, funct3, rd, opcode_op};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] funct3, input logic [4:0] rd);
        return {imm, rs1, funct3, rd, opcode_op_imm};
    endfunction

    // mostly x0..x5 so that dependences pile up
    function automatic logic [reg_addr_width-1:0] pick_reg();
        logic [reg_addr_width-1:0] r;
        if ($urandom_range(0, 7) == 0) begin
            r = reg_addr_width'($urandom_range(0, 31));
        end else begin
            r = reg_addr_width'($urandom_range(0, 5));
        end
        return r;
    endfunction

    function automatic logic [31:0] random_word();
        int          kind;
        logic [2:0]  funct3;
        logic [6:0]  funct7;
        logic [31:0] word;
        kind   = $urandom_range(0, 19);
        funct3 = 3'($urandom_range(0, 7));
        if (kind < 9) begin
            funct7 = (funct3 == 3'd0 && $urandom_range(0, 1) == 1) ? 7'h20 : 7'h00;
            word   = enc_r(funct7, pick_reg(), pick_reg(), funct3, pick_reg());
        end else if (kind < 17) begin
            word = enc_i(12'($urandom), pick_reg(), funct3, pick_reg());
        end else begin
            word = $urandom; // nearly always outside the subset
        end
        return word;
    endfunction

    task automatic issue(input logic [31:0] word);
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= word;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            instr_valid <= 1'b0;
        end
    endtask

    initial begin
        int gap;
        int waited;
        int total;
        void'($urandom(seed_value));
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        phase       = 2'd0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        phase <= 2'd1;

        issue(enc_i(12'd5, 5'd1, 3'b000, 5'd1));          // reads x1 straight after reset
        issue(enc_i(12'd3, 5'd1, 3'b000, 5'd1));          // ex forward
        issue(enc_r(7'h00, 5'd1, 5'd1, 3'b000, 5'd2));    // x1 in ex and mem, both operands
        issue(enc_i(12'hfff, 5'd2, 3'b000, 5'd0));        // write to x0
        issue(enc_r(7'h20, 5'd0, 5'd2, 3'b000, 5'd3));    // reads x0
        idle(1);
        issue(enc_r(7'h00, 5'd2, 5'd1, 3'b001, 5'd4));    // both operands from the register file
        idle(2);
        issue(enc_r(7'h00, 5'd4, 5'd3, 3'b010, 5'd5));    // x4 forwarded from wb
        issue(enc_r(7'h01, 5'd4, 5'd3, 3'b000, 5'd5));    // bad funct7, bubble
        issue(enc_i(12'h800, 5'd5, 3'b010, 5'd5));        // slti with negative imm
        idle(1);

        phase <= 2'd2;
        for (int n = 0; n < random_count; n++) begin
            issue(random_word());
            gap = ($urandom_range(0, 1) == 0) ? 0 : $urandom_range(1, 3);
            idle(gap);
        end
        idle(1);

        waited = 0;
        while (pending != 0 && waited < drain_limit) begin
            @(posedge clk);
            waited++;
        end
        if (pending != 0) begin
            $display("timeout: %0d retires still outstanding after %0d cycles", pending, waited);
        end else begin
            idle(8); // catch stray late retires
        end
        total = mismatch_count + missing_count + unexpected_count;
        $display("errors: %0d mismatch, %0d missing retire, %0d unexpected retire",
                 mismatch_count, missing_count, unexpected_count);
        if (total == 0 && pending == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
